//--- include/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// ----------------------------------------
// Address split: tag | index | word offset
// ----------------------------------------
`define CACHE_ADDR_W      12
`define CACHE_TAG_W       6
`define CACHE_INDEX_W     4
`define CACHE_OFFSET_W    2

// Geometry
`define CACHE_SETS        16
`define CACHE_WORD_W      32
`define CACHE_LINE_W      128   // 4 words per line

// Backing store
`define CACHE_MEM_LATENCY 6     // Cycles from request to mem_ack

`endif

//--- src/cache_pkg.sv
`include "cache_defs.svh"

package cache_pkg;

	// ----------------------------------------
	// CPU side
	// ----------------------------------------
	typedef struct packed {
		logic [`CACHE_ADDR_W-1:0] addr;   // Word address
		logic [`CACHE_WORD_W-1:0] wdata;
		logic                     write;  // 1 = store, 0 = load
	} cache_req_t;

	// ----------------------------------------
	// Memory side
	// ----------------------------------------
	typedef struct packed {
		logic [`CACHE_TAG_W-1:0]   tag;
		logic [`CACHE_INDEX_W-1:0] index;
	} line_addr_t;

	typedef struct packed {
		line_addr_t               addr;
		logic [`CACHE_LINE_W-1:0] data;   // Only meaningful for writes
		logic                     write;
	} mem_req_t;

	// Controller states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_WRITE_BACK,
		ST_ALLOCATE,
		ST_FLUSH_SCAN,
		ST_FLUSH_WB,
		ST_RESPOND
	} ctrl_state_t;

endpackage

//--- src/cache_way.sv
`include "cache_defs.svh"

module cache_way (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [`CACHE_INDEX_W-1:0] index,
	input  logic [`CACHE_TAG_W-1:0]   tag,
	input  logic                      wr_en,
	input  logic [`CACHE_LINE_W-1:0]  wr_line,
	input  logic                      wr_dirty,
	input  logic                      wr_valid,
	output logic                      hit,
	output logic [`CACHE_LINE_W-1:0]  rd_line,
	output logic [`CACHE_TAG_W-1:0]   rd_tag,
	output logic                      rd_valid,
	output logic                      rd_dirty
);

	// ----------------------------------------
	// Storage
	// ----------------------------------------
	logic [`CACHE_TAG_W-1:0]  tag_mem  [`CACHE_SETS];
	logic [`CACHE_LINE_W-1:0] data_mem [`CACHE_SETS];
	logic [`CACHE_SETS-1:0]   valid_q;
	logic [`CACHE_SETS-1:0]   dirty_q;

	// Asynchronous read of the selected set
	assign rd_line  = data_mem[index];
	assign rd_tag   = tag_mem[index];
	assign rd_valid = valid_q[index];
	assign rd_dirty = dirty_q[index];

	// Tag compare
	assign hit = rd_valid && (rd_tag == tag);

	// ----------------------------------------
	// Write port
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (wr_en) begin
			valid_q[index] <= wr_valid;
			dirty_q[index] <= wr_dirty;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			tag_mem[index]  <= tag;      // Tag follows every line write
			data_mem[index] <= wr_line;
		end
	end

endmodule

//--- src/line_memory.sv
`include "cache_defs.svh"

module line_memory (
	input  logic                     clk,
	input  logic                     rst_n,
	input  cache_pkg::mem_req_t      mem_req,
	input  logic                     mem_req_valid,
	output logic                     mem_ack,
	output logic [`CACHE_LINE_W-1:0] mem_rdata
);

	localparam int LATENCY = `CACHE_MEM_LATENCY;
	localparam int DEPTH   = 1 << (`CACHE_TAG_W + `CACHE_INDEX_W);
	localparam int CNT_W   = $clog2(LATENCY + 1);

	logic [`CACHE_LINE_W-1:0] mem [DEPTH];
	cache_pkg::mem_req_t      req_q;
	logic                     busy;
	logic [CNT_W-1:0]         cnt;    // Cycles since the request was taken
	logic                     done;

	// Backing store starts out all zero
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	assign done = busy && (cnt == CNT_W'(LATENCY - 1));

	// ----------------------------------------
	// Latency counter
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			cnt     <= '0;
			mem_ack <= 1'b0;
		end else begin
			mem_ack <= done;                // Ack lands LATENCY cycles after the request
			if (done) begin
				busy <= 1'b0;
			end else if (busy) begin
				cnt <= cnt + 1'b1;
			end else if (mem_req_valid) begin
				busy <= 1'b1;
				cnt  <= CNT_W'(1);
			end
		end
	end

	// Request latch and array access
	always_ff @(posedge clk) begin
		if (!busy && mem_req_valid) begin
			req_q <= mem_req;
		end
		if (done) begin
			if (req_q.write) begin
				mem[req_q.addr] <= req_q.data;
			end else begin
				mem_rdata <= mem[req_q.addr];
			end
		end
	end

	// The controller must wait for mem_ack before its next request
	a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
		busy |-> !mem_req_valid)
		else $error("line_memory: request issued while busy");

endmodule

//--- src/cache_controller.sv
`include "cache_defs.svh"

module cache_controller (
	input  logic                     clk,
	input  logic                     rst_n,
	input  cache_pkg::cache_req_t    req,
	input  logic                     req_valid,
	output logic                     req_ready,
	input  logic                     flush_req,
	output logic                     flush_done,
	output logic                     rsp_valid,
	output logic [`CACHE_WORD_W-1:0] rsp_data,
	output cache_pkg::mem_req_t      mem_req,
	output logic                     mem_req_valid,
	input  logic                     mem_ack,
	input  logic [`CACHE_LINE_W-1:0] mem_rdata
);

	cache_pkg::ctrl_state_t     state_q;
	cache_pkg::ctrl_state_t     state_d;
	cache_pkg::cache_req_t      req_q;
	cache_pkg::line_addr_t      req_line;
	logic [`CACHE_OFFSET_W-1:0] req_offset;

	logic [`CACHE_SETS-1:0]     lru_q;       // Per set: the way to replace next
	logic                       victim_q;
	logic [`CACHE_INDEX_W:0]    flush_cnt;   // {set, way}
	logic [`CACHE_INDEX_W-1:0]  flush_set;
	logic                       flush_way;
	logic                       flush_last;
	logic                       flush_dirty;
	logic                       flush_step;

	// Way ports
	logic [`CACHE_INDEX_W-1:0]  way_index;
	logic [1:0]                 way_wr_en;
	logic [`CACHE_LINE_W-1:0]   way_wr_line;
	logic                       way_wr_dirty;
	logic                       way_wr_valid;
	logic [1:0]                 hit;
	logic [1:0]                 rd_valid;
	logic [1:0]                 rd_dirty;
	logic [`CACHE_LINE_W-1:0]   rd_line [2];
	logic [`CACHE_TAG_W-1:0]    rd_tag  [2];

	logic                       any_hit;
	logic [`CACHE_LINE_W-1:0]   hit_line;
	logic [`CACHE_LINE_W-1:0]   merged_line;
	logic [`CACHE_WORD_W-1:0]   hit_word;
	logic                       victim;
	logic                       victim_dirty;
	logic                       mem_issue;
	cache_pkg::mem_req_t        mem_req_d;

	assign req_ready  = (state_q == cache_pkg::ST_IDLE);
	assign req_line   = cache_pkg::line_addr_t'(req_q.addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W]);
	assign req_offset = req_q.addr[`CACHE_OFFSET_W-1:0];

	assign flush_set  = flush_cnt[`CACHE_INDEX_W:1];
	assign flush_way  = flush_cnt[0];
	assign flush_last = &flush_cnt;
	assign way_index  = (state_q == cache_pkg::ST_FLUSH_SCAN || state_q == cache_pkg::ST_FLUSH_WB) ?
		flush_set : req_line.index;

	// ----------------------------------------
	// Ways
	// ----------------------------------------
	for (genvar w = 0; w < 2; w++) begin : g_way
		cache_way u_way (
			.clk      (clk),
			.rst_n    (rst_n),
			.index    (way_index),
			.tag      (req_line.tag),
			.wr_en    (way_wr_en[w]),
			.wr_line  (way_wr_line),
			.wr_dirty (way_wr_dirty),
			.wr_valid (way_wr_valid),
			.hit      (hit[w]),
			.rd_line  (rd_line[w]),
			.rd_tag   (rd_tag[w]),
			.rd_valid (rd_valid[w]),
			.rd_dirty (rd_dirty[w])
		);
	end

	// Hit data, word select and store merge
	assign any_hit  = |hit;
	assign hit_line = hit[1] ? rd_line[1] : rd_line[0];
	assign hit_word = hit_line[req_offset*`CACHE_WORD_W +: `CACHE_WORD_W];

	always_comb begin
		merged_line = hit_line;
		merged_line[req_offset*`CACHE_WORD_W +: `CACHE_WORD_W] = req_q.wdata;
	end

	// Victim: an empty way first, else the LRU way
	always_comb begin
		if (!rd_valid[0]) begin
			victim = 1'b0;
		end else if (!rd_valid[1]) begin
			victim = 1'b1;
		end else begin
			victim = lru_q[req_line.index];
		end
	end

	assign victim_dirty = rd_valid[victim] && rd_dirty[victim];
	assign flush_dirty  = rd_valid[flush_way] && rd_dirty[flush_way];
	assign flush_step   = (state_q == cache_pkg::ST_FLUSH_SCAN && !flush_dirty) ||
		(state_q == cache_pkg::ST_FLUSH_WB && mem_ack);

	// ----------------------------------------
	// Next state
	// ----------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			cache_pkg::ST_IDLE: begin
				if (flush_req) begin
					state_d = cache_pkg::ST_FLUSH_SCAN;
				end else if (req_valid) begin
					state_d = cache_pkg::ST_LOOKUP;
				end
			end
			cache_pkg::ST_LOOKUP: begin
				if (any_hit) begin
					state_d = cache_pkg::ST_RESPOND;
				end else if (victim_dirty) begin
					state_d = cache_pkg::ST_WRITE_BACK;
				end else begin
					state_d = cache_pkg::ST_ALLOCATE;
				end
			end
			cache_pkg::ST_WRITE_BACK: if (mem_ack) state_d = cache_pkg::ST_ALLOCATE;
			cache_pkg::ST_ALLOCATE:   if (mem_ack) state_d = cache_pkg::ST_LOOKUP;  // Retry
			cache_pkg::ST_FLUSH_SCAN: begin
				if (flush_dirty) begin
					state_d = cache_pkg::ST_FLUSH_WB;
				end else if (flush_last) begin
					state_d = cache_pkg::ST_IDLE;
				end
			end
			cache_pkg::ST_FLUSH_WB: begin
				if (mem_ack) begin
					state_d = flush_last ? cache_pkg::ST_IDLE : cache_pkg::ST_FLUSH_SCAN;
				end
			end
			default: state_d = cache_pkg::ST_IDLE;   // ST_RESPOND
		endcase
	end

	// Way writes: store hit, refill, invalidate during flush
	always_comb begin
		way_wr_en    = '0;
		way_wr_line  = merged_line;
		way_wr_dirty = 1'b0;
		way_wr_valid = 1'b0;
		case (state_q)
			cache_pkg::ST_LOOKUP: begin
				if (any_hit && req_q.write) begin
					way_wr_en    = hit;
					way_wr_dirty = 1'b1;
					way_wr_valid = 1'b1;
				end
			end
			cache_pkg::ST_ALLOCATE: begin
				if (mem_ack) begin
					way_wr_en[victim_q] = 1'b1;
					way_wr_line         = mem_rdata;
					way_wr_valid        = 1'b1;
				end
			end
			cache_pkg::ST_FLUSH_SCAN: if (!flush_dirty) way_wr_en[flush_way] = 1'b1;
			cache_pkg::ST_FLUSH_WB:   if (mem_ack) way_wr_en[flush_way] = 1'b1;
			default: ;
		endcase
	end

	// Memory requests
	always_comb begin
		mem_issue       = 1'b0;
		mem_req_d.addr  = req_line;
		mem_req_d.data  = '0;
		mem_req_d.write = 1'b0;
		case (state_q)
			cache_pkg::ST_LOOKUP: begin
				if (!any_hit) begin
					mem_issue = 1'b1;
					if (victim_dirty) begin       // Evict first
						mem_req_d.addr  = '{tag: rd_tag[victim], index: req_line.index};
						mem_req_d.data  = rd_line[victim];
						mem_req_d.write = 1'b1;
					end
				end
			end
			cache_pkg::ST_WRITE_BACK: mem_issue = mem_ack;  // Refill read after eviction
			cache_pkg::ST_FLUSH_SCAN: begin
				if (flush_dirty) begin
					mem_issue       = 1'b1;
					mem_req_d.addr  = '{tag: rd_tag[flush_way], index: flush_set};
					mem_req_d.data  = rd_line[flush_way];
					mem_req_d.write = 1'b1;
				end
			end
			default: ;
		endcase
	end

	// ----------------------------------------
	// Registers
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q       <= cache_pkg::ST_IDLE;
			lru_q         <= '0;
			victim_q      <= 1'b0;
			flush_cnt     <= '0;
			mem_req_valid <= 1'b0;
			rsp_valid     <= 1'b0;
			flush_done    <= 1'b0;
		end else begin
			state_q       <= state_d;
			mem_req_valid <= mem_issue;
			rsp_valid     <= (state_q == cache_pkg::ST_LOOKUP) && any_hit;
			flush_done    <= flush_step && flush_last;
			if (state_q == cache_pkg::ST_LOOKUP) begin
				if (any_hit) begin
					lru_q[req_line.index] <= hit[0];  // Other way becomes LRU
				end else begin
					victim_q <= victim;
				end
			end
			if (flush_step) begin
				flush_cnt <= flush_cnt + 1'b1;    // Wraps to zero after the last entry
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req_ready && req_valid && !flush_req) begin
			req_q <= req;
		end
		if (mem_issue) begin
			mem_req <= mem_req_d;
		end
		if (state_q == cache_pkg::ST_LOOKUP && any_hit) begin
			rsp_data <= req_q.write ? '0 : hit_word;
		end
	end

	// A line lives in at most one way
	a_single_hit: assert property (@(posedge clk) disable iff (!rst_n)
		!(hit[0] && hit[1]))
		else $error("cache_controller: both ways hit");

	a_rsp_in_respond: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid |-> (state_q == cache_pkg::ST_RESPOND))
		else $error("cache_controller: rsp_valid outside ST_RESPOND");

endmodule

//--- src/cache_top.sv
`include "cache_defs.svh"

module cache_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  cache_pkg::cache_req_t    req,
	input  logic                     req_valid,
	output logic                     req_ready,
	input  logic                     flush_req,
	output logic                     flush_done,
	output logic                     rsp_valid,
	output logic [`CACHE_WORD_W-1:0] rsp_data
);

	// Controller to backing memory
	cache_pkg::mem_req_t      mem_req;
	logic                     mem_req_valid;
	logic                     mem_ack;
	logic [`CACHE_LINE_W-1:0] mem_rdata;

	cache_controller u_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.req           (req),
		.req_valid     (req_valid),
		.req_ready     (req_ready),
		.flush_req     (flush_req),
		.flush_done    (flush_done),
		.rsp_valid     (rsp_valid),
		.rsp_data      (rsp_data),
		.mem_req       (mem_req),
		.mem_req_valid (mem_req_valid),
		.mem_ack       (mem_ack),
		.mem_rdata     (mem_rdata)
	);

	line_memory u_mem (
		.clk           (clk),
		.rst_n         (rst_n),
		.mem_req       (mem_req),
		.mem_req_valid (mem_req_valid),
		.mem_ack       (mem_ack),
		.mem_rdata     (mem_rdata)
	);

endmodule

//--- bench/tb_cache.sv
`include "cache_defs.svh"

module tb_cache;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int REQ_TIMEOUT   = 100;   // A dirty miss needs about 15 cycles
	localparam int FLUSH_TIMEOUT = 1000;  // 32 entries, each may write back

	logic                     clk;
	logic                     rst_n;
	cache_pkg::cache_req_t    req;
	logic                     req_valid;
	logic                     req_ready;
	logic                     flush_req;
	logic                     flush_done;
	logic                     rsp_valid;
	logic [`CACHE_WORD_W-1:0] rsp_data;

	logic [`CACHE_WORD_W-1:0] shadow [1 << `CACHE_ADDR_W];  // Last written word per address
	logic [31:0]              lfsr_state;
	int                       rsp_count;
	int                       flush_count;
	int                       req_count;
	int                       flush_issued;

	cache_top i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (req),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.flush_req  (flush_req),
		.flush_done (flush_done),
		.rsp_valid  (rsp_valid),
		.rsp_data   (rsp_data)
	);

	always #2 clk = ~clk;

	// Pulse counters, read by the main process on falling edges
	always @(posedge clk) begin
		if (!rst_n) begin
			rsp_count   <= 0;
			flush_count <= 0;
		end else begin
			if (rsp_valid) rsp_count <= rsp_count + 1;
			if (flush_done) flush_count <= flush_count + 1;
		end
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	task automatic stop_on_failure();
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0d ns: %s = %h, expected %h", $time, name, actual, expected);
			stop_on_failure();
		end
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
	endfunction

	task automatic random_word(output logic [31:0] w);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		w = v;
	endtask

	// Hex token to value, leading zero bytes are padding from %s
	function automatic logic [31:0] hex_value(input logic [63:0] tok);
		logic [31:0] v;
		logic [7:0]  c;
		v = '0;
		for (int i = 7; i >= 0; i--) begin
			c = tok[i*8 +: 8];
			if (c >= "0" && c <= "9") v = {v[27:0], c[3:0]};
			else if ((c >= "a" && c <= "f") || (c >= "A" && c <= "F")) v = {v[27:0], c[3:0] + 4'd9};
		end
		return v;
	endfunction

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		while (!req_ready) begin
			@(negedge clk);
			cycles++;
			if (cycles > REQ_TIMEOUT) begin
				$display("Timeout at %0d ns: req_ready stayed low", $time);
				stop_on_failure();
			end
		end
	endtask

	// Called on a falling edge; leaves req_valid high so the next request follows at once
	task automatic issue_request(input logic write, input logic [`CACHE_ADDR_W-1:0] addr,
		input logic [31:0] wdata, input logic [31:0] expected, input logic expect_hit);
		int cycles;
		req.addr  = addr;
		req.wdata = wdata;
		req.write = write;
		req_valid = 1'b1;
		wait_ready();                       // Accepted on the next rising edge
		req_count++;
		cycles = 0;
		while (!rsp_valid) begin
			@(negedge clk);
			cycles++;
			if (cycles > REQ_TIMEOUT) begin
				$display("Timeout at %0d ns: no response for address %h", $time, addr);
				stop_on_failure();
			end
		end
		check_value("rsp_data", rsp_data, expected);
		check_value("rsp_count", rsp_count, req_count - 1);  // This pulse not counted yet
		if (expect_hit) check_value("hit latency", cycles, 2);
	endtask

	task automatic run_flush();
		int cycles;
		req_valid = 1'b0;
		wait_ready();
		flush_req = 1'b1;
		flush_issued++;
		@(negedge clk);
		flush_req = 1'b0;
		cycles = 0;
		while (!flush_done) begin
			@(negedge clk);
			cycles++;
			if (cycles > FLUSH_TIMEOUT) begin
				$display("Timeout at %0d ns: flush_done never arrived", $time);
				stop_on_failure();
			end
		end
		check_value("flush_count", flush_count, flush_issued - 1);
	endtask

	// ----------------------------------------
	// Stimulus from the stim file
	// ----------------------------------------
	initial begin
		int                        fd;
		int                        code;
		logic [63:0]               op_tok;
		logic [63:0]               addr_tok;
		logic [63:0]               wdata_tok;
		logic [63:0]               exp_tok;
		logic [8*160-1:0]          line_buf;
		logic [31:0]               addr_word;
		logic [`CACHE_ADDR_W-1:0]  addr;
		logic [31:0]               wdata;
		logic [31:0]               expected;
		logic                      is_write;
		logic                      expect_hit;
		logic [`CACHE_ADDR_W-`CACHE_OFFSET_W-1:0] last_line;
		logic                      last_valid;
		bit                        at_end;

		clk          = 1'b0;
		rst_n        = 1'b0;
		req          = '0;
		req_valid    = 1'b0;
		flush_req    = 1'b0;
		lfsr_state   = 32'h3f0e_6f51;
		req_count    = 0;
		flush_issued = 0;
		last_line    = '0;
		last_valid   = 1'b0;
		at_end       = 1'b0;
		for (int i = 0; i < (1 << `CACHE_ADDR_W); i++) shadow[i] = '0;

		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_value("req_ready", req_ready, 1);
		check_value("rsp_valid", rsp_valid, 0);
		check_value("flush_done", flush_done, 0);

		fd = $fopen("bench/cache_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open bench/cache_stim.txt");
			stop_on_failure();
		end

		while (!at_end) begin
			code = $fscanf(fd, "%s", op_tok);
			if (code != 1) begin
				at_end = 1'b1;
			end else if (op_tok == "#") begin
				code = $fgets(line_buf, fd);  // Skip the rest of a comment line
			end else begin
				code = $fscanf(fd, "%s %s %s", addr_tok, wdata_tok, exp_tok);
				if (code != 3) begin
					$display("Stim line with operation %s has missing fields", op_tok);
					stop_on_failure();
				end
				if (op_tok == "F") begin
					run_flush();
					last_valid = 1'b0;
				end else if (op_tok == "R" || op_tok == "W") begin
					addr_word = hex_value(addr_tok);
					addr      = addr_word[`CACHE_ADDR_W-1:0];
					is_write  = (op_tok == "W");
					if (wdata_tok == "X") random_word(wdata);
					else wdata = hex_value(wdata_tok);
					if (exp_tok == "X") expected = shadow[addr];
					else expected = hex_value(exp_tok);
					// Same line as the previous access must still be resident
					expect_hit = last_valid &&
						(addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W] == last_line);
					issue_request(is_write, addr, wdata, expected, expect_hit);
					if (is_write) shadow[addr] = wdata;
					last_line  = addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W];
					last_valid = 1'b1;
				end else begin
					$display("Unknown operation %s in stim file", op_tok);
					stop_on_failure();
				end
			end
		end
		$fclose(fd);

		req_valid = 1'b0;
		repeat (4) @(negedge clk);
		check_value("rsp_count", rsp_count, req_count);     // No stray responses
		check_value("flush_count", flush_count, flush_issued);
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- bench/cache_stim.txt
# op addr wdata expect, hex; X in wdata takes LFSR data, X in expect takes the last written word
# F flushes and ignores its other fields; a write answers with 0
R 010 0 0
W 010 a5a50001 0
R 010 0 a5a50001
R 011 0 0
W 012 X 0
R 012 0 X
W 013 5a5a0013 0
R 010 0 a5a50001
# three tags on set 3 force dirty evictions
W 04c 11110001 0
W 08d 22220002 0
W 0ce 33330003 0
R 04c 0 11110001
R 08d 0 22220002
R 0ce 0 33330003
W 08f X 0
R 04c 0 11110001
R 08f 0 X
# dirty lines go back to memory on flush and are refilled
W 200 X 0
W 3f1 X 0
W 105 cafe0105 0
W 14a X 0
F 0 0 0
R 200 0 X
R 3f1 0 X
R 105 0 cafe0105
R 14a 0 X
R 012 0 X
R 013 0 5a5a0013
F 0 0 0
R 010 0 a5a50001
W fff 0000beef 0
R fff 0 0000beef
R ffe 0 0

//--- files.f
+incdir+include
src/cache_pkg.sv
src/cache_way.sv
src/line_memory.sv
src/cache_controller.sv
src/cache_top.sv
bench/tb_cache.sv

//--- Makefile
# Verilator flow for the cache testbench, run from the project root

TOP := tb_cache

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f files.f

# Build, run, and pass only if the pass message shows up
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f files.f -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
